/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = serial_tb
FILELIST  = files.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "STATUS: FAIL" >> $(LOG)
	@cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* common/uart_line_pkg.sv */
// Serial line and baud constants

package uart_line_pkg;

	localparam int fifo_depth  = 16;
	localparam int fifo_addr_w = 4;

	localparam int oversample = 16; // ticks per bit
	localparam int stop_bits  = 1;

	// clk cycles per 16x tick at 31250 baud from a 50 MHz clk
	localparam int mpu_divisor = 100;

endpackage

/* common/uart_reg_pkg.sv */
// 16550 and MPU-401 register maps

package uart_reg_pkg;

	// 16550 register addresses
	localparam logic [2:0] addr_rbr_thr = 3'd0; // also divisor low byte with DLAB set
	localparam logic [2:0] addr_ier     = 3'd1; // also divisor high byte with DLAB set
	localparam logic [2:0] addr_iir     = 3'd2;
	localparam logic [2:0] addr_lcr     = 3'd3;
	localparam logic [2:0] addr_lsr     = 3'd5;
	localparam logic [2:0] addr_scr     = 3'd7;

	// LCR fields, word length code 0..3 gives 5..8 data bits
	localparam int lcr_dlab_bit = 7;
	localparam int lcr_wlen_lsb = 0;

	localparam int lsr_dr_bit   = 0;
	localparam int lsr_thre_bit = 5;
	localparam int lsr_temt_bit = 6;

	localparam logic [7:0] lsr_reset = 8'h60; // idle transmitter, nothing received
	localparam logic [7:0] iir_none  = 8'h01;

	// received data wins over transmitter empty
	localparam logic [7:0] iir_rx_data   = 8'h04;
	localparam logic [7:0] iir_thr_empty = 8'h02;

	localparam logic [7:0] mpu_cmd_reset = 8'hFF;
	localparam logic [7:0] mpu_cmd_uart  = 8'h3F;
	localparam logic [7:0] mpu_ack       = 8'hFE;

	// both status bits are active low, the rest read 0
	localparam int mpu_stat_rx_bit = 7;
	localparam int mpu_stat_tx_bit = 6;

endpackage

/* files.f */
common/uart_reg_pkg.sv
common/uart_line_pkg.sv
rtl/byte_fifo.sv
uart/uart_tx.sv
uart/uart_rx.sv
uart/uart_regs.sv
rtl/mpu_port.sv
rtl/serial_top.sv
verification/serial_sva.sv
verification/serial_tb.sv

/* rtl/byte_fifo.sv */
// Byte FIFO

`timescale 1ns/1ps

module byte_fifo import uart_line_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       push,
	input  logic [7:0] din,
	input  logic       pop,
	output logic [7:0] dout,
	output logic       empty,
	output logic       full
);
	logic [7:0] mem [fifo_depth];
	logic [fifo_addr_w-1:0] wr_ptr, rd_ptr;
	logic [fifo_addr_w:0] count;
	logic do_push, do_pop;

	assign empty = (count == '0);
	assign full = (count == (fifo_addr_w + 1)'(fifo_depth));
	assign do_push = push & ~full;
	assign do_pop = pop & ~empty;
	assign dout = mem[rd_ptr]; // head word is visible without a pop

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count + (fifo_addr_w + 1)'(do_push) - (fifo_addr_w + 1)'(do_pop);
		end
	end

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= din;
	end

endmodule

/* rtl/mpu_port.sv */
// MPU-401 UART-mode port

`timescale 1ns/1ps

module mpu_port import uart_reg_pkg::*, uart_line_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       address,
	input  logic       write,
	input  logic [7:0] writedata,
	input  logic       read,
	input  logic       cs,
	input  logic       double_rate,
	input  logic       rx,
	output logic [7:0] readdata,
	output logic       tx,
	output logic       irq
);
	localparam int div_w = $clog2(mpu_divisor);

	logic [div_w-1:0] div_cnt, div_top;
	logic tick16;
	logic read_ack, dumb;
	logic [7:0] tx_hold;
	logic tx_pend, tx_busy;
	logic [7:0] rx_byte, rx_dout, status;
	logic rx_done, rx_empty;
	logic data_rd;

	assign div_top = double_rate ? div_w'(mpu_divisor / 2 - 1) : div_w'(mpu_divisor - 1);

	always_ff @(posedge clk) begin
		if (reset) begin
			div_cnt <= '0;
			tick16 <= 1'b0;
		end else begin
			tick16 <= (div_cnt >= div_top);
			div_cnt <= (div_cnt >= div_top) ? '0 : div_cnt + 1'b1;
		end
	end

	uart_tx tx_i (
		.clk(clk), .reset(reset), .tick16(tick16), .wlen(2'd3),
		.data(tx_hold), .start(tx_pend), .tx(tx), .busy(tx_busy)
	);

	uart_rx rx_i (
		.clk(clk), .reset(reset), .tick16(tick16), .wlen(2'd3),
		.rx(rx), .data(rx_byte), .done(rx_done)
	);

	// a pending acknowledge is read before any received byte
	assign data_rd = cs & read & ~address;

	byte_fifo rx_fifo_i (
		.clk(clk), .reset(reset), .push(rx_done), .din(rx_byte),
		.pop(data_rd & ~read_ack), .dout(rx_dout), .empty(rx_empty), .full()
	);

	always_comb begin
		status = 8'h00;
		status[mpu_stat_rx_bit] = ~(read_ack | ~rx_empty);
		status[mpu_stat_tx_bit] = tx_pend | tx_busy;
	end

	assign irq = read_ack | ~rx_empty;

	always_ff @(posedge clk) begin
		if (reset) begin
			read_ack <= 1'b0;
			dumb <= 1'b0;
			tx_pend <= 1'b0;
			readdata <= '0;
		end else begin
			if (tx_pend && !tx_busy)
				tx_pend <= 1'b0;
			if (cs && read)
				readdata <= address ? status : (read_ack ? mpu_ack : rx_dout);
			if (data_rd)
				read_ack <= 1'b0;
			if (cs && write && address) begin
				if (!dumb)
					read_ack <= 1'b1;
				if (writedata == mpu_cmd_reset)
					dumb <= 1'b0;
				if (writedata == mpu_cmd_uart)
					dumb <= 1'b1;
			end
			if (cs && write && !address)
				tx_pend <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (cs && write && !address)
			tx_hold <= writedata;
	end

endmodule

/* rtl/serial_top.sv */
// Serial port subsystem top

`timescale 1ns/1ps

module serial_top (
	input  logic       clk,
	input  logic       reset,
	input  logic [2:0] address,
	input  logic       write,
	input  logic [7:0] writedata,
	input  logic       read,
	input  logic       cs,
	output logic [7:0] readdata,
	input  logic       mpu_address,
	input  logic       mpu_write,
	input  logic [7:0] mpu_writedata,
	input  logic       mpu_read,
	input  logic       mpu_cs,
	output logic [7:0] mpu_readdata,
	output logic       tx,
	input  logic       rx,
	output logic       mpu_tx,
	input  logic       mpu_rx,
	input  logic       double_rate,
	output logic       irq,
	output logic       mpu_irq
);
	logic tick16, tx_start, tx_busy, rx_done;
	logic [1:0] wlen;
	logic [7:0] tx_byte, rx_byte;

	uart_regs regs_i (
		.clk(clk), .reset(reset), .address(address), .write(write),
		.writedata(writedata), .read(read), .cs(cs), .tx_busy(tx_busy),
		.rx_byte(rx_byte), .rx_done(rx_done), .readdata(readdata), .tick16(tick16),
		.wlen(wlen), .tx_byte(tx_byte), .tx_start(tx_start), .irq(irq)
	);

	uart_tx tx_i (
		.clk(clk), .reset(reset), .tick16(tick16), .wlen(wlen),
		.data(tx_byte), .start(tx_start), .tx(tx), .busy(tx_busy)
	);

	uart_rx rx_i (
		.clk(clk), .reset(reset), .tick16(tick16), .wlen(wlen),
		.rx(rx), .data(rx_byte), .done(rx_done)
	);

	mpu_port mpu_i (
		.clk(clk), .reset(reset), .address(mpu_address), .write(mpu_write),
		.writedata(mpu_writedata), .read(mpu_read), .cs(mpu_cs),
		.double_rate(double_rate), .rx(mpu_rx), .readdata(mpu_readdata),
		.tx(mpu_tx), .irq(mpu_irq)
	);

endmodule

/* uart/uart_regs.sv */
// 16550 register block

`timescale 1ns/1ps

module uart_regs import uart_reg_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic [2:0] address,
	input  logic       write,
	input  logic [7:0] writedata,
	input  logic       read,
	input  logic       cs,
	input  logic       tx_busy,
	input  logic [7:0] rx_byte,
	input  logic       rx_done,
	output logic [7:0] readdata,
	output logic       tick16,
	output logic [1:0] wlen,
	output logic [7:0] tx_byte,
	output logic       tx_start,
	output logic       irq
);
	logic [7:0] dll, dlm, lcr, scr;
	logic [1:0] ier;
	logic [15:0] div_cnt;
	logic [15:0] div_eff;
	logic dlab;
	logic wr_en, rd_en;
	logic rx_empty, tx_empty;
	logic [7:0] rx_dout;
	logic [7:0] lsr_val, iir_val, rd_val;

	assign dlab  = lcr[lcr_dlab_bit];
	assign wlen  = lcr[lcr_wlen_lsb +: 2];
	assign wr_en = cs & write;
	assign rd_en = cs & read;

	assign div_eff = ({dlm, dll} == 16'd0) ? 16'd1 : {dlm, dll};

	always_ff @(posedge clk) begin
		if (reset) begin
			div_cnt <= '0;
			tick16 <= 1'b0;
		end else if (div_cnt >= div_eff - 16'd1) begin // >= catches a divisor lowered mid-count
			div_cnt <= '0;
			tick16 <= 1'b1;
		end else begin
			div_cnt <= div_cnt + 16'd1;
			tick16 <= 1'b0;
		end
	end

	byte_fifo rx_fifo_i (
		.clk(clk), .reset(reset),
		.push(rx_done), .din(rx_byte),
		.pop(rd_en && address == addr_rbr_thr && !dlab),
		.dout(rx_dout), .empty(rx_empty), .full()
	);

	byte_fifo tx_fifo_i (
		.clk(clk), .reset(reset),
		.push(wr_en && address == addr_rbr_thr && !dlab), .din(writedata),
		.pop(tx_start),
		.dout(tx_byte), .empty(tx_empty), .full()
	);

	assign tx_start = ~tx_empty & ~tx_busy; // transmitter takes the byte in this same cycle

	always_comb begin
		lsr_val = 8'h00;
		lsr_val[lsr_dr_bit]   = ~rx_empty;
		lsr_val[lsr_thre_bit] = tx_empty;
		lsr_val[lsr_temt_bit] = tx_empty & ~tx_busy;
		if (ier[0] && !rx_empty)
			iir_val = iir_rx_data;
		else if (ier[1] && tx_empty)
			iir_val = iir_thr_empty;
		else
			iir_val = iir_none;
		case (address)
			addr_rbr_thr: rd_val = dlab ? dll : rx_dout;
			addr_ier:     rd_val = dlab ? dlm : {6'b0, ier};
			addr_iir:     rd_val = iir_val;
			addr_lcr:     rd_val = lcr;
			addr_lsr:     rd_val = lsr_val;
			addr_scr:     rd_val = scr;
			default:      rd_val = 8'h00; // no modem registers
		endcase
	end

	assign irq = (ier[0] & ~rx_empty) | (ier[1] & tx_empty);

	always_ff @(posedge clk) begin
		if (reset) begin
			dll <= '0;
			dlm <= '0;
			lcr <= '0;
			ier <= '0;
			readdata <= '0;
		end else begin
			if (rd_en)
				readdata <= rd_val;
			if (wr_en) begin
				case (address)
					addr_rbr_thr: if (dlab) dll <= writedata;
					addr_ier:     if (dlab) dlm <= writedata; else ier <= writedata[1:0];
					addr_lcr:     lcr <= writedata;
					default:      ;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en && address == addr_scr)
			scr <= writedata;
	end

endmodule

/* uart/uart_rx.sv */
// Serial receiver

`timescale 1ns/1ps

module uart_rx import uart_line_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       tick16,
	input  logic [1:0] wlen,
	input  logic       rx,
	output logic [7:0] data,
	output logic       done
);
	localparam logic [1:0] st_idle  = 2'd0;
	localparam logic [1:0] st_start = 2'd1;
	localparam logic [1:0] st_data  = 2'd2;
	localparam logic [1:0] st_stop  = 2'd3;

	logic rx_s1, rx_s2, rx_prev;
	logic [1:0] state;
	logic [$clog2(oversample)-1:0] tick_cnt;
	logic [2:0] bit_cnt;
	logic [7:0] shreg;
	logic mid, bit_end;

	assign mid     = tick16 && (tick_cnt == ($clog2(oversample))'(oversample / 2 - 1));
	assign bit_end = tick16 && (tick_cnt == ($clog2(oversample))'(oversample - 1));

	always_ff @(posedge clk) begin
		if (reset) begin
			rx_s1 <= 1'b1;
			rx_s2 <= 1'b1;
			rx_prev <= 1'b1;
			state <= st_idle;
			tick_cnt <= '0;
			bit_cnt <= '0;
			done <= 1'b0;
		end else begin
			rx_s1 <= rx;
			rx_s2 <= rx_s1;
			rx_prev <= rx_s2;
			done <= 1'b0;
			if (tick16)
				tick_cnt <= tick_cnt + 1'b1;
			case (state)
				st_idle: if (rx_prev && !rx_s2) begin
					tick_cnt <= '0;
					state <= st_start;
				end
				st_start: if (mid) begin
					tick_cnt <= '0; // from here every sample sits mid-bit
					bit_cnt <= '0;
					state <= rx_s2 ? st_idle : st_data; // glitch, not a start bit
				end
				st_data: if (bit_end) begin
					tick_cnt <= '0;
					if (bit_cnt == {1'b0, wlen} + 3'd4)
						state <= st_stop;
					else
						bit_cnt <= bit_cnt + 3'd1;
				end
				st_stop: if (bit_end) begin
					done <= rx_s2; // framing error drops the byte
					state <= st_idle;
				end
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == st_start && mid)
			shreg <= '0;
		else if (state == st_data && bit_end)
			shreg[bit_cnt] <= rx_s2;
		if (state == st_stop && bit_end)
			data <= shreg;
	end

endmodule

/* uart/uart_tx.sv */
// Serial transmitter

`timescale 1ns/1ps

module uart_tx import uart_line_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       tick16,
	input  logic [1:0] wlen,
	input  logic [7:0] data,
	input  logic       start,
	output logic       tx,
	output logic       busy
);
	localparam logic [2:0] st_idle  = 3'd0;
	localparam logic [2:0] st_load  = 3'd1;
	localparam logic [2:0] st_start = 3'd2;
	localparam logic [2:0] st_data  = 3'd3;
	localparam logic [2:0] st_stop  = 3'd4;

	logic [2:0] state;
	logic [$clog2(oversample)-1:0] tick_cnt;
	logic [2:0] bit_cnt;
	logic [7:0] shreg;
	logic bit_end;

	assign busy = (state != st_idle);
	assign bit_end = tick16 && (tick_cnt == ($clog2(oversample))'(oversample - 1));

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= st_idle;
			tx <= 1'b1;
			tick_cnt <= '0;
			bit_cnt <= '0;
		end else begin
			if (tick16)
				tick_cnt <= bit_end ? '0 : tick_cnt + 1'b1;
			case (state)
				st_idle: if (start) state <= st_load;
				st_load: if (tick16) begin // start bit is aligned to the tick grid
					tx <= 1'b0;
					tick_cnt <= '0;
					state <= st_start;
				end
				st_start: if (bit_end) begin
					tx <= shreg[0];
					bit_cnt <= {1'b0, wlen} + 3'd4; // bits still to send after this one
					state <= st_data;
				end
				st_data: if (bit_end) begin
					if (bit_cnt == 3'd0) begin
						tx <= 1'b1;
						bit_cnt <= 3'(stop_bits - 1);
						state <= st_stop;
					end else begin
						tx <= shreg[0];
						bit_cnt <= bit_cnt - 3'd1;
					end
				end
				st_stop: if (bit_end) begin
					if (bit_cnt == 3'd0)
						state <= st_idle;
					else
						bit_cnt <= bit_cnt - 3'd1;
				end
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == st_idle && start)
			shreg <= data;
		else if (bit_end && (state == st_start || state == st_data))
			shreg <= shreg >> 1;
	end

endmodule

/* verification/serial_sva.sv */
// FIFO, transmit line and interrupt assertions

`timescale 1ns/1ps

module serial_sva import uart_reg_pkg::*, uart_line_pkg::*; (
	input logic                   clk,
	input logic                   reset,
	input logic                   empty,
	input logic                   full,
	input logic [fifo_addr_w:0]   count,
	input logic [fifo_addr_w-1:0] wr_ptr,
	input logic [fifo_addr_w-1:0] rd_ptr,
	input logic                   tx,
	input logic                   busy,
	input logic                   irq,
	input logic [7:0]             iir
);
	// pointers meet only when the FIFO is empty or full
	flags_at_ptr_match: assert property (@(posedge clk) disable iff (reset)
		(empty || full) == (wr_ptr == rd_ptr))
		else $error("FIFO flags disagree with the read and write pointers");

	count_in_range: assert property (@(posedge clk) disable iff (reset)
		count <= (fifo_addr_w + 1)'(fifo_depth))
		else $error("FIFO count %0d is above the depth", count);

	idle_line_high: assert property (@(posedge clk) disable iff (reset) !busy |-> tx)
		else $error("transmit line is low while the transmitter is idle");

	irq_has_source: assert property (@(posedge clk) disable iff (reset) irq |-> iir != iir_none)
		else $error("irq is high while IIR reports no source");

endmodule

bind byte_fifo serial_sva fifo_sva_i (
	.clk(clk), .reset(reset), .empty(empty), .full(full), .count(count),
	.wr_ptr(wr_ptr), .rd_ptr(rd_ptr),
	.tx(1'b1), .busy(1'b0), .irq(1'b0), .iir(8'h00)
);

bind uart_tx serial_sva tx_sva_i (
	.clk(clk), .reset(reset), .empty(1'b1), .full(1'b0), .count('0),
	.wr_ptr('0), .rd_ptr('0),
	.tx(tx), .busy(busy), .irq(1'b0), .iir(8'h00)
);

bind uart_regs serial_sva regs_sva_i (
	.clk(clk), .reset(reset), .empty(1'b1), .full(1'b0), .count('0),
	.wr_ptr('0), .rd_ptr('0),
	.tx(1'b1), .busy(1'b0), .irq(irq), .iir(iir_val)
);

/* verification/serial_tb.sv */
// Serial subsystem testbench

`timescale 1ns/1ps

module serial_tb import uart_reg_pkg::*, uart_line_pkg::*; ();

	// 8 loopback, 3 word length, 1 interrupt and 6 MPU bytes
	localparam int bytes_sent = 18;
	localparam int cycle_limit = 4 * (bytes_sent * 10 * oversample * mpu_divisor) + 2000;

	logic clk = 1'b0;
	logic reset;
	logic [2:0] address;
	logic write, read, cs;
	logic [7:0] writedata, readdata;
	logic mpu_address, mpu_write, mpu_read, mpu_cs;
	logic [7:0] mpu_writedata, mpu_readdata;
	logic double_rate;
	logic tx, mpu_tx, irq, mpu_irq;

	integer seed;
	int cycles;
	int checks = 0;
	int errors = 0;
	int tests = 0;
	logic [7:0] sent_q[$];
	logic mpu_dumb = 1'b0;
	logic mpu_ack_pend = 1'b0;

	always #2 clk = ~clk;

	serial_top dut_i (
		.clk(clk), .reset(reset), .address(address), .write(write),
		.writedata(writedata), .read(read), .cs(cs), .readdata(readdata),
		.mpu_address(mpu_address), .mpu_write(mpu_write), .mpu_writedata(mpu_writedata),
		.mpu_read(mpu_read), .mpu_cs(mpu_cs), .mpu_readdata(mpu_readdata),
		.tx(tx), .rx(tx), .mpu_tx(mpu_tx), .mpu_rx(mpu_tx), // both channels looped back
		.double_rate(double_rate), .irq(irq), .mpu_irq(mpu_irq)
	);

	function automatic logic [7:0] lsr_model(input logic rx_waiting, input logic thr_empty,
		input logic tx_idle);
		logic [7:0] v;
		v = 8'h00;
		v[lsr_dr_bit] = rx_waiting;
		v[lsr_thre_bit] = thr_empty;
		v[lsr_temt_bit] = thr_empty & tx_idle;
		return v;
	endfunction

	function automatic logic [7:0] iir_model(input logic [1:0] ier, input logic rx_waiting,
		input logic thr_empty);
		if (ier[0] && rx_waiting)
			return iir_rx_data;
		if (ier[1] && thr_empty)
			return iir_thr_empty;
		return iir_none;
	endfunction

	function automatic logic [7:0] mpu_status_model(input logic rx_ready, input logic tx_active);
		logic [7:0] v;
		v = 8'h00;
		v[mpu_stat_rx_bit] = ~rx_ready; // active low
		v[mpu_stat_tx_bit] = tx_active;
		return v;
	endfunction

	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error at %0t ns: %s is 0x%02h, expected 0x%02h", $time, name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error at %0t ns: %s is %b, expected %b", $time, name, got, exp);
		end
	endtask

	task automatic report_test(input string name, input int errs_before);
		tests++;
		if (errors == errs_before)
			$display("test %s: ok", name);
		else
			$display("test %s: %0d errors", name, errors - errs_before);
	endtask

	task automatic bus_write(input logic [2:0] a, input logic [7:0] d);
		address = a;
		writedata = d;
		write = 1'b1;
		cs = 1'b1;
		@(posedge clk);
		#1;
		write = 1'b0;
		cs = 1'b0;
	endtask

	task automatic bus_read(input logic [2:0] a, output logic [7:0] d);
		address = a;
		read = 1'b1;
		cs = 1'b1;
		@(posedge clk);
		#1;
		read = 1'b0;
		cs = 1'b0;
		d = readdata; // registered at the edge just passed
	endtask

	task automatic mpu_bus_write(input logic a, input logic [7:0] d);
		mpu_address = a;
		mpu_writedata = d;
		mpu_write = 1'b1;
		mpu_cs = 1'b1;
		@(posedge clk);
		#1;
		mpu_write = 1'b0;
		mpu_cs = 1'b0;
	endtask

	task automatic mpu_bus_read(input logic a, output logic [7:0] d);
		mpu_address = a;
		mpu_read = 1'b1;
		mpu_cs = 1'b1;
		@(posedge clk);
		#1;
		mpu_read = 1'b0;
		mpu_cs = 1'b0;
		d = mpu_readdata;
	endtask

	task automatic wait_rx_ready();
		logic [7:0] st;
		bus_read(addr_lsr, st);
		while (!st[lsr_dr_bit])
			bus_read(addr_lsr, st);
	endtask

	task automatic wait_tx_idle();
		logic [7:0] st;
		bus_read(addr_lsr, st);
		while (!st[lsr_temt_bit])
			bus_read(addr_lsr, st);
	endtask

	task automatic wait_mpu_rx();
		logic [7:0] st;
		mpu_bus_read(1'b1, st);
		while (st[mpu_stat_rx_bit])
			mpu_bus_read(1'b1, st);
	endtask

	task automatic wait_mpu_tx_idle();
		logic [7:0] st;
		mpu_bus_read(1'b1, st);
		while (st[mpu_stat_tx_bit])
			mpu_bus_read(1'b1, st);
	endtask

	task automatic test_reset();
		int e0 = errors;
		logic [7:0] got;
		check_byte("readdata", readdata, 8'h00);
		check_byte("mpu_readdata", mpu_readdata, 8'h00);
		check_bit("tx", tx, 1'b1);
		check_bit("mpu_tx", mpu_tx, 1'b1);
		check_bit("irq", irq, 1'b0);
		check_bit("mpu_irq", mpu_irq, 1'b0);
		bus_read(addr_lsr, got);
		check_byte("lsr", got, lsr_model(1'b0, 1'b1, 1'b1));
		bus_read(addr_iir, got);
		check_byte("iir", got, iir_model(2'b00, 1'b0, 1'b1));
		mpu_bus_read(1'b1, got);
		check_byte("mpu status", got, mpu_status_model(1'b0, 1'b0));
		report_test("reset values", e0);
	endtask

	task automatic test_loopback();
		int e0 = errors;
		logic [7:0] div, b, got;
		div = 8'(1 + $unsigned($random(seed)) % 4);
		bus_write(addr_lcr, 8'h80);
		bus_write(addr_rbr_thr, div);
		bus_write(addr_ier, 8'h00);
		bus_write(addr_lcr, 8'h03); // 8 data bits
		repeat (8) begin
			b = 8'($random(seed));
			sent_q.push_back(b);
			bus_write(addr_rbr_thr, b);
		end
		while (sent_q.size() > 0) begin
			wait_rx_ready();
			bus_read(addr_rbr_thr, got);
			check_byte("rbr", got, sent_q.pop_front());
		end
		report_test("16550 loopback", e0);
	endtask

	task automatic test_word_length();
		int e0 = errors;
		logic [7:0] b, got;
		for (int w = 0; w < 3; w++) begin
			wait_tx_idle();
			bus_write(addr_lcr, 8'(w));
			b = 8'($random(seed));
			bus_write(addr_rbr_thr, b);
			wait_rx_ready();
			bus_read(addr_rbr_thr, got);
			check_byte("rbr", got, b & 8'((1 << (w + 5)) - 1));
		end
		wait_tx_idle();
		bus_write(addr_lcr, 8'h03);
		report_test("word length", e0);
	endtask

	task automatic test_interrupts();
		int e0 = errors;
		logic [7:0] b, got;
		bus_write(addr_ier, 8'h01);
		check_bit("irq", irq, 1'b0);
		b = 8'($random(seed));
		bus_write(addr_rbr_thr, b);
		while (!irq) begin
			@(posedge clk);
			#1;
		end
		bus_read(addr_iir, got);
		check_byte("iir", got, iir_model(2'b01, 1'b1, 1'b1));
		bus_read(addr_rbr_thr, got);
		check_byte("rbr", got, b);
		check_bit("irq", irq, 1'b0);
		bus_write(addr_ier, 8'h02);
		check_bit("irq", irq, 1'b1);
		bus_read(addr_iir, got);
		check_byte("iir", got, iir_model(2'b10, 1'b0, 1'b1));
		b = 8'($random(seed));
		bus_write(addr_scr, b);
		bus_read(addr_scr, got);
		check_byte("scr", got, b);
		bus_write(addr_ier, 8'h00);
		check_bit("irq", irq, 1'b0);
		report_test("interrupts", e0);
	endtask

	task automatic mpu_command(input logic [7:0] cmd);
		logic [7:0] got;
		mpu_bus_write(1'b1, cmd);
		if (!mpu_dumb)
			mpu_ack_pend = 1'b1; // only acknowledged outside dumb mode
		if (cmd == mpu_cmd_reset)
			mpu_dumb = 1'b0;
		if (cmd == mpu_cmd_uart)
			mpu_dumb = 1'b1;
		check_bit("mpu_irq", mpu_irq, mpu_ack_pend);
		mpu_bus_read(1'b1, got);
		check_byte("mpu status", got, mpu_status_model(mpu_ack_pend, 1'b0));
		if (mpu_ack_pend) begin
			mpu_bus_read(1'b0, got);
			check_byte("mpu data", got, mpu_ack);
			mpu_ack_pend = 1'b0;
			check_bit("mpu_irq", mpu_irq, 1'b0);
		end
	endtask

	task automatic test_mpu_commands();
		int e0 = errors;
		mpu_command(mpu_cmd_reset);
		mpu_command(mpu_cmd_uart);
		mpu_command(mpu_cmd_uart);
		mpu_command(mpu_cmd_reset);
		mpu_command(mpu_cmd_reset);
		mpu_command(mpu_cmd_uart); // left in dumb mode for the data test
		report_test("MPU commands", e0);
	endtask

	task automatic test_mpu_data();
		int e0 = errors;
		logic [7:0] b, got;
		repeat (6) begin
			b = 8'($random(seed));
			wait_mpu_tx_idle();
			mpu_bus_write(1'b0, b);
			sent_q.push_back(b);
		end
		while (sent_q.size() > 0) begin
			wait_mpu_rx();
			check_bit("mpu_irq", mpu_irq, 1'b1);
			mpu_bus_read(1'b0, got);
			check_byte("mpu data", got, sent_q.pop_front());
		end
		wait_mpu_tx_idle();
		check_bit("mpu_irq", mpu_irq, 1'b0);
		mpu_bus_read(1'b1, got);
		check_byte("mpu status", got, mpu_status_model(1'b0, 1'b0));
		report_test("MPU data", e0);
	endtask

	initial begin
		cycles = 0;
		while (cycles < cycle_limit) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: the DUT did not finish within %0d cycles", cycle_limit);
		$display("STATUS: FAIL");
		$finish;
	end

	initial begin
		seed = 58;
		reset = 1'b1;
		address = 3'd0;
		write = 1'b0;
		writedata = 8'h00;
		read = 1'b0;
		cs = 1'b0;
		mpu_address = 1'b0;
		mpu_write = 1'b0;
		mpu_writedata = 8'h00;
		mpu_read = 1'b0;
		mpu_cs = 1'b0;
		double_rate = 1'b0;
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;
		test_reset();
		test_loopback();
		test_word_length();
		test_interrupts();
		test_mpu_commands();
		test_mpu_data();
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule
